/* verilog/smc_defines.svh */
`ifndef SMC_DEFINES_SVH
`define SMC_DEFINES_SVH

// ----------------------------------------------------------
// External access timing
// ----------------------------------------------------------

// Strobe low cycles per external byte, at least 1
`define SMC_STROBE_CYCLES 2

// ----------------------------------------------------------
// Bus widths
// ----------------------------------------------------------

// External SRAM byte address
`define SMC_EXT_ADDR_W 16

// AHB address and data
`define SMC_AHB_W 32

`endif

/* verilog/smc_pkg.sv */
`default_nettype none

`include "smc_defines.svh"

package smc_pkg;

  // AHB transfer type
  typedef enum logic [1:0] {
    TRN_IDLE   = 2'b00,
    TRN_BUSY   = 2'b01,
    TRN_NONSEQ = 2'b10,
    TRN_SEQ    = 2'b11
  } htrans_e;

  // AHB transfer size, 64 bit and up not supported
  typedef enum logic [2:0] {
    SZ_BYTE = 3'b000,
    SZ_HALF = 3'b001,
    SZ_WORD = 3'b010
  } hsize_e;

  typedef enum logic [1:0] {
    RSP_OKAY  = 2'b00,
    RSP_ERROR = 2'b01
  } hresp_e;

  // External access sequencer
  typedef enum logic [1:0] {
    ST_IDLE,   // No access, chip select high
    ST_SETUP,  // Address setup before strobe
    ST_STROBE, // Strobe low, more cycles to go
    ST_HOLD    // Last strobe cycle of a lane
  } smc_state_e;

  // One AHB address phase
  typedef struct packed {
    logic [`SMC_AHB_W-1:0] addr;
    logic [1:0]            xfer_size; // Low bits of hsize
    logic                  n_read;    // High for a write
  } smc_req_t;

  // External SRAM bus, strobes active low
  typedef struct packed {
    logic [`SMC_EXT_ADDR_W-1:0] ext_addr;
    logic                       n_cs;
    logic                       n_oe;
    logic                       n_we;
    logic [7:0]                 ext_wdata;
  } ext_bus_t;

endpackage

`default_nettype wire

/* verilog/smc_ahb_lite_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "smc_defines.svh"

module smc_ahb_lite_if (
  input  wire logic                  hclk20,
  input  wire logic                  n_sys_reset20,
  input  wire logic                  hsel,
  input  wire logic [`SMC_AHB_W-1:0] haddr,
  input  wire smc_pkg::htrans_e      htrans,
  input  wire logic                  hwrite,
  input  wire smc_pkg::hsize_e       hsize,
  input  wire logic [`SMC_AHB_W-1:0] hwdata,
  input  wire logic                  hready,     // Muxed bus ready
  input  wire logic                  smc_done,   // Last strobe cycle of a lane
  input  wire logic                  mac_done,   // Current lane is the last one
  input  wire logic [`SMC_AHB_W-1:0] read_data,
  output smc_pkg::smc_req_t          req,
  output logic                       new_access,
  output logic [`SMC_AHB_W-1:0]      write_data,
  output logic [`SMC_AHB_W-1:0]      hrdata,
  output logic                       hready_out,
  output smc_pkg::hresp_e            hresp
);

  import smc_pkg::*;

  logic addr_phase;  // Active transfer accepted this cycle
  logic misaligned;
  logic mis_err;
  logic r_ready;     // Registered part of ready
  logic r_hresp;     // Second ERROR cycle pending

  // ----------------------------------------------------------
  // Address phase decode
  // ----------------------------------------------------------

  assign req.addr      = haddr;
  assign req.xfer_size = hsize[1:0];
  assign req.n_read    = hwrite; // Write means read strobe unused

  assign addr_phase = hsel && hready &&
                      ((htrans == TRN_NONSEQ) || (htrans == TRN_SEQ));

  always_comb
  begin
    case (hsize)
      SZ_HALF: misaligned = haddr[0];
      SZ_WORD: misaligned = |haddr[1:0];
      default: misaligned = 1'b0; // Bytes always aligned
    endcase
  end

  assign mis_err    = addr_phase && misaligned;
  assign new_access = addr_phase && !misaligned;

  // ----------------------------------------------------------
  // Response and ready
  // ----------------------------------------------------------

  always_ff @(posedge hclk20 or negedge n_sys_reset20)
  begin
    if (!n_sys_reset20)
    begin
      hresp   <= RSP_OKAY;
      r_hresp <= 1'b0;
    end
    else if (mis_err)
    begin
      hresp   <= RSP_ERROR; // First cycle, ready low
      r_hresp <= 1'b1;
    end
    else if (r_hresp)
    begin
      hresp   <= RSP_ERROR; // Second cycle, ready high
      r_hresp <= 1'b0;
    end
    else
      hresp <= RSP_OKAY;
  end

  always_ff @(posedge hclk20 or negedge n_sys_reset20)
  begin
    if (!n_sys_reset20)
      r_ready <= 1'b1;
    else if (mis_err)
      r_ready <= 1'b0;
    else if (r_hresp)
      r_ready <= 1'b1;
    else if (hready)
      r_ready <= !new_access; // Idle, busy or unselected complete at once
  end

  // Wait state ends on the last strobe of the last lane
  assign hready_out = r_ready || (smc_done && mac_done);

  assign hrdata     = read_data;
  assign write_data = hwdata;

  // Two cycle ERROR response
  a_error_two_cycle: assert property (
    @(posedge hclk20) disable iff (!n_sys_reset20)
    (hresp == RSP_ERROR && !hready_out) |=> (hresp == RSP_ERROR && hready_out)
  ) else $error("ERROR response not completed with ready high");

endmodule

`default_nettype wire

/* verilog/smc_state_machine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "smc_defines.svh"

module smc_state_machine (
  input  wire logic                  hclk20,
  input  wire logic                  n_sys_reset20,
  input  wire smc_pkg::smc_req_t     req,
  input  wire logic                  new_access,
  input  wire logic [`SMC_AHB_W-1:0] write_data,
  input  wire logic [1:0]            lane_idx,
  input  wire logic                  mac_done,
  output smc_pkg::ext_bus_t          ext_bus,
  output logic                       lane_start,
  output logic                       smc_done,
  output smc_pkg::smc_req_t          cur_req
);

  import smc_pkg::*;

  localparam int STROBE_N = `SMC_STROBE_CYCLES;
  localparam int EXT_W    = `SMC_EXT_ADDR_W;

  // Counter value on the cycle before HOLD
  localparam logic [3:0] CNT_HOLD = 4'(STROBE_N - 2);

  smc_state_e            state;
  smc_state_e            state_nxt;
  logic [3:0]            strobe_cnt; // Strobe cycles already spent in lane
  logic [`SMC_AHB_W-1:0] wdata_q;    // Write word for all lanes
  logic                  strobing;

  // ----------------------------------------------------------
  // Sequencer
  // ----------------------------------------------------------

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
        if (new_access)
          state_nxt = ST_SETUP;
      ST_SETUP:
        state_nxt = (STROBE_N > 1) ? ST_STROBE : ST_HOLD;
      ST_STROBE:
        if (strobe_cnt == CNT_HOLD)
          state_nxt = ST_HOLD;
      ST_HOLD:
        // Next lane, back to back access, or done
        if (!mac_done || new_access)
          state_nxt = ST_SETUP;
        else
          state_nxt = ST_IDLE;
      default:
        state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge hclk20 or negedge n_sys_reset20)
  begin
    if (!n_sys_reset20)
    begin
      state      <= ST_IDLE;
      strobe_cnt <= '0;
      cur_req    <= '0;
    end
    else
    begin
      state <= state_nxt;
      if (state == ST_STROBE)
        strobe_cnt <= strobe_cnt + 4'd1;
      else
        strobe_cnt <= '0;
      if (new_access)
        cur_req <= req; // Address phase held for the whole access
    end
  end

  // Data phase of the AHB transfer is the first SETUP
  always_ff @(posedge hclk20)
  begin
    if (state == ST_SETUP && lane_idx == 2'd0)
      wdata_q <= write_data;
  end

  assign lane_start = (state == ST_SETUP);
  assign smc_done   = (state == ST_HOLD);
  assign strobing   = (state == ST_STROBE) || (state == ST_HOLD);

  // ----------------------------------------------------------
  // External bus
  // ----------------------------------------------------------

  always_comb
  begin
    ext_bus.ext_addr  = cur_req.addr[EXT_W-1:0] + {{(EXT_W-2){1'b0}}, lane_idx};
    ext_bus.n_cs      = (state == ST_IDLE);
    ext_bus.n_oe      = !(strobing && !cur_req.n_read);
    ext_bus.n_we      = !(strobing && cur_req.n_read);
    ext_bus.ext_wdata = wdata_q[{lane_idx, 3'b000} +: 8]; // Little endian lane
  end

  // Write address held through every strobe cycle of a lane
  a_we_addr_stable: assert property (
    @(posedge hclk20) disable iff (!n_sys_reset20)
    !ext_bus.n_we |-> $stable(ext_bus.ext_addr)
  ) else $error("External address changed while write enable low");

endmodule

`default_nettype wire

/* verilog/smc_mac.sv */
`timescale 1ns/1ps
`default_nettype none

`include "smc_defines.svh"

module smc_mac (
  input  wire logic              hclk20,
  input  wire logic              n_sys_reset20,
  input  wire smc_pkg::smc_req_t cur_req,
  input  wire logic              lane_start,
  input  wire logic              smc_done,
  input  wire logic [7:0]        ext_rdata,
  output logic [1:0]             lane_idx,
  output logic                   mac_done,
  output logic [`SMC_AHB_W-1:0]  read_data
);

  import smc_pkg::*;

  logic [2:0]            lane_total; // Bytes in the transfer
  logic [`SMC_AHB_W-1:0] rd_buf;     // Completed read lanes

  // ----------------------------------------------------------
  // Lane count
  // ----------------------------------------------------------

  always_comb
  begin
    case (cur_req.xfer_size)
      2'b00:   lane_total = 3'd1;
      2'b01:   lane_total = 3'd2;
      default: lane_total = 3'd4; // Word
    endcase
  end

  assign mac_done = ({1'b0, lane_idx} == (lane_total - 3'd1));

  // Back to zero after the last lane, ready for the next access
  always_ff @(posedge hclk20 or negedge n_sys_reset20)
  begin
    if (!n_sys_reset20)
      lane_idx <= 2'd0;
    else if (smc_done)
    begin
      if (mac_done)
        lane_idx <= 2'd0;
      else
        lane_idx <= lane_idx + 2'd1;
    end
  end

  // ----------------------------------------------------------
  // Read data assembly
  // ----------------------------------------------------------

  always_ff @(posedge hclk20)
  begin
    if (lane_start && lane_idx == 2'd0)
      rd_buf <= '0; // Unused upper lanes read as zero
    else if (smc_done && !cur_req.n_read)
      rd_buf[{lane_idx, 3'b000} +: 8] <= ext_rdata;
  end

  // Current lane bypasses the buffer so the last byte is seen with ready
  always_comb
  begin
    read_data                          = rd_buf;
    read_data[{lane_idx, 3'b000} +: 8] = ext_rdata;
  end

  a_lane_in_range: assert property (
    @(posedge hclk20) disable iff (!n_sys_reset20)
    {1'b0, lane_idx} < lane_total
  ) else $error("Lane index past end of transfer");

endmodule

`default_nettype wire

/* verilog/smc_lite.sv */
`timescale 1ns/1ps
`default_nettype none

`include "smc_defines.svh"

module smc_lite (
  input  wire logic                  hclk20,
  input  wire logic                  n_sys_reset20,
  input  wire logic                  hsel,
  input  wire logic [`SMC_AHB_W-1:0] haddr,
  input  wire smc_pkg::htrans_e      htrans,
  input  wire logic                  hwrite,
  input  wire smc_pkg::hsize_e       hsize,
  input  wire logic [`SMC_AHB_W-1:0] hwdata,
  input  wire logic                  hready,
  input  wire logic [7:0]            ext_rdata, // SRAM read byte
  output logic [`SMC_AHB_W-1:0]      hrdata,
  output logic                       hready_out,
  output smc_pkg::hresp_e            hresp,
  output smc_pkg::ext_bus_t          ext_bus
);

  import smc_pkg::*;

  // ----------------------------------------------------------
  // Internal strobes and data
  // ----------------------------------------------------------

  smc_req_t              req;        // Live address phase
  smc_req_t              cur_req;    // Latched for the access
  logic                  new_access;
  logic [`SMC_AHB_W-1:0] write_data;
  logic [`SMC_AHB_W-1:0] read_data;
  logic                  lane_start;
  logic                  smc_done;
  logic                  mac_done;
  logic [1:0]            lane_idx;

  smc_ahb_lite_if u_ahb_if (
    .hclk20        (hclk20),
    .n_sys_reset20 (n_sys_reset20),
    .hsel          (hsel),
    .haddr         (haddr),
    .htrans        (htrans),
    .hwrite        (hwrite),
    .hsize         (hsize),
    .hwdata        (hwdata),
    .hready        (hready),
    .smc_done      (smc_done),
    .mac_done      (mac_done),
    .read_data     (read_data),
    .req           (req),
    .new_access    (new_access),
    .write_data    (write_data),
    .hrdata        (hrdata),
    .hready_out    (hready_out),
    .hresp         (hresp)
  );

  smc_state_machine u_state_machine (
    .hclk20        (hclk20),
    .n_sys_reset20 (n_sys_reset20),
    .req           (req),
    .new_access    (new_access),
    .write_data    (write_data),
    .lane_idx      (lane_idx),
    .mac_done      (mac_done),
    .ext_bus       (ext_bus),
    .lane_start    (lane_start),
    .smc_done      (smc_done),
    .cur_req       (cur_req)
  );

  smc_mac u_mac (
    .hclk20        (hclk20),
    .n_sys_reset20 (n_sys_reset20),
    .cur_req       (cur_req),
    .lane_start    (lane_start),
    .smc_done      (smc_done),
    .ext_rdata     (ext_rdata),
    .lane_idx      (lane_idx),
    .mac_done      (mac_done),
    .read_data     (read_data)
  );

endmodule

`default_nettype wire

/* sim/sram_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "smc_defines.svh"

module sram_model (
  input  wire smc_pkg::ext_bus_t ext_bus,
  output logic [7:0]             ext_rdata
);

  import smc_pkg::*;

  localparam int DEPTH = 1 << `SMC_EXT_ADDR_W;

  logic [7:0] mem [0:DEPTH-1];
  integer     i;

  // Power-up contents, every address bit matters
  initial
  begin
    for (i = 0; i < DEPTH; i = i + 1)
      mem[i] = i[7:0] ^ i[15:8] ^ 8'h3C;
  end

  // Array follows the bus while selected with write enable low
  always @(ext_bus)
  begin
    if (!ext_bus.n_cs && !ext_bus.n_we)
      mem[ext_bus.ext_addr] = ext_bus.ext_wdata;
  end

  // Undriven bus reads as X
  assign ext_rdata = (!ext_bus.n_cs && !ext_bus.n_oe) ? mem[ext_bus.ext_addr] : 8'hxx;

endmodule

`default_nettype wire

/* sim/tb_smc_lite.sv */
`timescale 1ns/1ps
`default_nettype none

`include "smc_defines.svh"

module tb_smc_lite;

  import smc_pkg::*;

  localparam int STROBE_N = `SMC_STROBE_CYCLES;
  localparam int WAIT_MAX = 64; // Cycles before a wait gives up

  logic                  hclk20;
  logic                  n_sys_reset20;
  logic                  hsel;
  logic [`SMC_AHB_W-1:0] haddr;
  htrans_e               htrans;
  logic                  hwrite;
  hsize_e                hsize;
  logic [`SMC_AHB_W-1:0] hwdata;
  logic [`SMC_AHB_W-1:0] hrdata;
  logic                  hready_out; // Single slave so also the muxed ready
  hresp_e                hresp;
  ext_bus_t              ext_bus;
  logic [7:0]            ext_rdata;

  logic [7:0]  shadow [0:65535]; // Reference memory
  integer      seed;
  integer      i;
  int          data_cycles;      // Length of last data phase
  hresp_e      resp_first;
  hresp_e      resp_last;
  int          reads_issued  = 0;
  int          reads_checked = 0;
  int          we_cycles     = 0; // Write strobe low cycles seen
  logic [31:0] cmp_exp;
  string       cmp_name;
  logic [31:0] rnd;
  logic [31:0] addr;
  hsize_e      sz;

  smc_lite DUT (
    .hclk20        (hclk20),
    .n_sys_reset20 (n_sys_reset20),
    .hsel          (hsel),
    .haddr         (haddr),
    .htrans        (htrans),
    .hwrite        (hwrite),
    .hsize         (hsize),
    .hwdata        (hwdata),
    .hready        (hready_out),
    .ext_rdata     (ext_rdata),
    .hrdata        (hrdata),
    .hready_out    (hready_out),
    .hresp         (hresp),
    .ext_bus       (ext_bus)
  );

  sram_model u_sram (.ext_bus(ext_bus), .ext_rdata(ext_rdata));

  always #2 hclk20 = ~hclk20; // 4 ns period

  // ----------------------------------------------------------
  // Reference model and checks
  // ----------------------------------------------------------

  function automatic int lane_count(input hsize_e size);
    case (size)
      SZ_BYTE: return 1;
      SZ_HALF: return 2;
      default: return 4;
    endcase
  endfunction

  // Lane k is byte addr+k on bits 8k+7..8k with unused lanes zero
  function automatic logic [31:0] expected_read(input logic [31:0] a, input hsize_e size);
    logic [31:0] word;
    int          k;
    word = '0;
    for (k = 0; k < lane_count(size); k++)
      word[8*k +: 8] = shadow[a[15:0] + 16'(k)];
    return word;
  endfunction

  function automatic void shadow_write(input logic [31:0] a, input hsize_e size,
                                       input logic [31:0] data);
    int k;
    for (k = 0; k < lane_count(size); k++)
      shadow[a[15:0] + 16'(k)] = data[8*k +: 8];
  endfunction

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
      stop_on_error($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
  endtask

  // Read data compared on the completing data cycle
  always @(negedge hclk20)
  begin
    if (reads_checked != reads_issued && hready_out)
    begin
      check(cmp_name, cmp_exp, hrdata);
      reads_checked = reads_checked + 1;
    end
  end

  always @(negedge hclk20)
  begin
    if (!ext_bus.n_we)
      we_cycles = we_cycles + 1;
  end

  // ----------------------------------------------------------
  // AHB driver entered and left 1 ns after a rising edge
  // ----------------------------------------------------------

  task automatic bus_access(input logic wr, input logic [31:0] a, input hsize_e size,
                            input logic [31:0] wdata, input logic arm_compare);
    int wait_cnt;
    hsel     = 1'b1;
    htrans   = TRN_NONSEQ;
    haddr    = a;
    hwrite   = wr;
    hsize    = size;
    wait_cnt = 0;
    @(negedge hclk20);
    while (!hready_out) // Address phase stretched by the slave
    begin
      wait_cnt++;
      if (wait_cnt > WAIT_MAX)
        stop_on_error("Timeout: hready_out stayed low during the address phase");
      @(negedge hclk20);
    end
    @(posedge hclk20);
    #1;
    htrans = TRN_IDLE; // Data phase
    hwdata = wdata;
    if (arm_compare)
      reads_issued++;
    @(negedge hclk20);
    resp_first  = hresp;
    data_cycles = 1;
    while (!hready_out)
    begin
      if (data_cycles > WAIT_MAX)
        stop_on_error("Timeout: data phase never completed");
      @(negedge hclk20);
      data_cycles++;
    end
    resp_last = hresp;
    @(posedge hclk20);
    #1;
  endtask

  task automatic write_access(input logic [31:0] a, input hsize_e size, input logic [31:0] data,
                              input string name);
    int we_before;
    we_before = we_cycles;
    bus_access(1'b1, a, size, data, 1'b0);
    shadow_write(a, size, data);
    check({name, " resp"}, RSP_OKAY, resp_last);
    check({name, " cycles"}, lane_count(size) * (1 + STROBE_N), data_cycles);
    check({name, " strobes"}, lane_count(size) * STROBE_N, we_cycles - we_before);
  endtask

  task automatic read_access(input logic [31:0] a, input hsize_e size, input string name);
    cmp_exp  = expected_read(a, size);
    cmp_name = name;
    bus_access(1'b0, a, size, 32'h0, 1'b1);
    if (reads_checked != reads_issued)
      stop_on_error({name, ": read data was never compared"});
    check({name, " resp"}, RSP_OKAY, resp_last);
    check({name, " cycles"}, lane_count(size) * (1 + STROBE_N), data_cycles);
  endtask

  task automatic misaligned_access(input logic wr, input logic [31:0] a, input hsize_e size,
                                   input string name);
    int we_before;
    we_before = we_cycles;
    bus_access(wr, a, size, 32'hDEAD_BEEF, 1'b0);
    check({name, " first resp"}, RSP_ERROR, resp_first);
    check({name, " last resp"}, RSP_ERROR, resp_last);
    check({name, " cycles"}, 2, data_cycles); // Ready low then high
    check({name, " strobes"}, 0, we_cycles - we_before);
  endtask

  // Transfer that must finish in one cycle with no SRAM activity
  task automatic idle_access(input logic sel, input htrans_e trn, input string name);
    int we_before;
    we_before = we_cycles;
    hsel   = sel;
    htrans = trn;
    haddr  = 32'h0000_0060;
    hwrite = 1'b1;
    hsize  = SZ_WORD;
    @(posedge hclk20);
    #1;
    hsel   = 1'b0;
    htrans = TRN_IDLE;
    hwdata = 32'h1234_5678;
    @(negedge hclk20);
    check({name, " ready"}, 1, hready_out);
    check({name, " resp"}, RSP_OKAY, hresp);
    repeat (2) @(posedge hclk20); // Past the first strobe a started write would make
    #1;
    check({name, " strobes"}, 0, we_cycles - we_before);
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------

  initial
  begin
    seed          = 85261;
    hclk20        = 1'b0;
    n_sys_reset20 = 1'b0;
    hsel          = 1'b0;
    haddr         = '0;
    htrans        = TRN_IDLE;
    hwrite        = 1'b0;
    hsize         = SZ_BYTE;
    hwdata        = '0;
    for (i = 0; i < 65536; i = i + 1)
      shadow[i] = i[7:0] ^ i[15:8] ^ 8'h3C; // Same fill as the SRAM
    repeat (16) @(posedge hclk20);
    #1;
    n_sys_reset20 = 1'b1;

    // Idle bus after reset
    @(negedge hclk20);
    check("reset hready_out", 1, hready_out);
    check("reset hresp", RSP_OKAY, hresp);
    check("reset strobes", 3'b111, {ext_bus.n_cs, ext_bus.n_oe, ext_bus.n_we});
    @(posedge hclk20);
    #1;

    // Aligned accesses of each size
    write_access(32'h0000_0010, SZ_WORD, 32'hA1B2_C3D4, "word write");
    read_access(32'h0000_0010, SZ_WORD, "word read");
    for (i = 0; i < 4; i = i + 1)
      read_access(32'h0000_0010 + i, SZ_BYTE, $sformatf("byte lane %0d read", i));
    write_access(32'h0000_0022, SZ_HALF, 32'hFFFF_5AA5, "half write");
    read_access(32'h0000_0022, SZ_HALF, "half read");
    read_access(32'h0000_0020, SZ_WORD, "half in word read");
    write_access(32'h0000_0035, SZ_BYTE, 32'h0000_00E7, "byte write");
    read_access(32'h0000_0035, SZ_BYTE, "byte read");
    read_access(32'h0000_0034, SZ_WORD, "byte in word read");

    // Misaligned transfers
    misaligned_access(1'b1, 32'h0000_0041, SZ_HALF, "misaligned half write");
    misaligned_access(1'b1, 32'h0000_0042, SZ_WORD, "misaligned word write");
    misaligned_access(1'b0, 32'h0000_0043, SZ_WORD, "misaligned word read");
    read_access(32'h0000_0040, SZ_WORD, "after misaligned read");

    // Nothing reaches the SRAM
    idle_access(1'b1, TRN_IDLE, "idle");
    idle_access(1'b1, TRN_BUSY, "busy");
    idle_access(1'b0, TRN_NONSEQ, "unselected nonseq");
    idle_access(1'b0, TRN_SEQ, "unselected seq");
    read_access(32'h0000_0060, SZ_WORD, "after idle read");

    // Random aligned traffic in a 256 byte window
    for (i = 0; i < 200; i = i + 1)
    begin
      rnd = $random(seed);
      case (rnd % 3)
        0:       sz = SZ_BYTE;
        1:       sz = SZ_HALF;
        default: sz = SZ_WORD;
      endcase
      rnd  = $random(seed);
      addr = {rnd[31:16], 8'h01, rnd[7:0]}; // Upper bits ignored by the DUT
      if (sz == SZ_HALF)
        addr[0] = 1'b0;
      else if (sz == SZ_WORD)
        addr[1:0] = 2'b00;
      rnd = $random(seed);
      if (rnd[0])
        write_access(addr, sz, $random(seed), $sformatf("random %0d write", i));
      else
        read_access(addr, sz, $sformatf("random %0d read", i));
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+verilog
verilog/smc_pkg.sv
verilog/smc_ahb_lite_if.sv
verilog/smc_state_machine.sv
verilog/smc_mac.sv
verilog/smc_lite.sv
sim/sram_model.sv
sim/tb_smc_lite.sv

/* Makefile */
TOP = tb_smc_lite

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -Wno-fatal -f project.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir
